/* lpe.f */
lpe_pkg.sv
lpe_operand_buffer.sv
lpe_control_unit.sv
lpe_mac.sv
lpe_output_port.sv
lpe_top.sv
lpe_assertions.sv
tb_lpe.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lpe
FILELIST  ?= lpe.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_lpe.sv */
`timescale 1ns/1ps

module tb_lpe
  import lpe_pkg::*;
();

  // Total input beats over all tests set the watchdog limit
  localparam int total_beats     = 89;
  localparam int watchdog_cycles = total_beats * 40 + 200;

  logic       clk;
  logic       rst;
  logic       left_in_valid;
  logic       left_in_ready;
  left_beat_t left_in;
  logic       up_in_valid;
  logic       up_in_ready;
  up_beat_t   up_in;
  logic       right_out_valid;
  logic       right_out_ready;
  left_beat_t right_out;
  logic       down_out_valid;
  logic       down_out_ready;
  up_beat_t   down_out;
  lpe_err_t   err;

  // Stimulus and expected streams
  left_beat_t left_stim[$];
  up_beat_t   up_stim[$];
  left_beat_t exp_right[$];
  up_beat_t   exp_down[$];
  lpe_err_t   exp_err[$];

  int          errors;
  int          checks;
  logic [31:0] lfsr_state = 32'h3f1fc90b;

  lpe_top DUT (
    .clk             (clk),
    .rst             (rst),
    .left_in_valid   (left_in_valid),
    .left_in_ready   (left_in_ready),
    .left_in         (left_in),
    .up_in_valid     (up_in_valid),
    .up_in_ready     (up_in_ready),
    .up_in           (up_in),
    .right_out_valid (right_out_valid),
    .right_out_ready (right_out_ready),
    .right_out       (right_out),
    .down_out_valid  (down_out_valid),
    .down_out_ready  (down_out_ready),
    .down_out        (down_out),
    .err             (err)
  );

  bind lpe_top lpe_assertions u_assertions (
    .clk             (clk),
    .rst             (rst),
    .right_out_valid (right_out_valid),
    .right_out_ready (right_out_ready),
    .right_out       (right_out),
    .down_out_valid  (down_out_valid),
    .down_out_ready  (down_out_ready),
    .down_out        (down_out),
    .err             (err)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Galois LFSR stepped once per bit
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'h80200003;
    end
    return out;
  endfunction

  function automatic logic [ACC_WIDTH-1:0] rand_bits(input int width);
    logic [ACC_WIDTH-1:0] value;
    value = '0;
    for (int i = 0; i < width; i++) begin
      value = {value[ACC_WIDTH-2:0], lfsr_bit()};
    end
    return value;
  endfunction

  task automatic check_left_beat(input left_beat_t exp, input left_beat_t act, input string name);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error at %0t: %s expected data=%h last=%b, got data=%h last=%b",
               $time, name, exp.data, exp.last, act.data, act.last);
    end
  endtask

  task automatic check_up_beat(input up_beat_t exp, input up_beat_t act, input string name);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error at %0t: %s expected data=%h user=%h last=%b, got data=%h user=%h last=%b",
               $time, name, exp.data, exp.user, exp.last, act.data, act.user, act.last);
    end
  endtask

  task automatic check_err(input lpe_err_t exp, input lpe_err_t act, input string name);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error at %0t: %s expected unaligned=%b user_flag=%b, got unaligned=%b user_flag=%b",
               $time, name, exp.unaligned, exp.user_flag, act.unaligned, act.user_flag);
    end
  endtask

  // Output monitors sample on the transfer edge
  always @(posedge clk) begin
    if (!rst && right_out_valid && right_out_ready) begin
      if (exp_right.size() == 0) begin
        errors++;
        $display("unexpected beat on right_out at %0t", $time);
      end else begin
        check_left_beat(exp_right.pop_front(), right_out, "right_out");
      end
    end
    if (!rst && down_out_valid && down_out_ready) begin
      if (exp_down.size() == 0) begin
        errors++;
        $display("unexpected beat on down_out at %0t", $time);
      end else begin
        check_up_beat(exp_down.pop_front(), down_out, "down_out");
      end
    end
    if (!rst && err !== '0) begin
      if (exp_err.size() == 0) begin
        errors++;
        $display("unexpected error pulse at %0t", $time);
      end else begin
        check_err(exp_err.pop_front(), err, "err");
      end
    end
  end

  // One dot product with results from above and the own result
  task automatic build_product(input int n_pairs, input int n_rslt, input bit aligned);
    left_beat_t                 lb;
    up_beat_t                   ub;
    lpe_err_t                   e;
    logic [ACC_WIDTH-1:0]       r;
    logic signed [OP_WIDTH-1:0] a;
    logic signed [OP_WIDTH-1:0] b;
    longint                     sum;
    sum = 0;
    for (int i = 0; i < n_pairs; i++) begin
      r = rand_bits(OP_WIDTH);
      a = r[OP_WIDTH-1:0];
      r = rand_bits(OP_WIDTH);
      b = r[OP_WIDTH-1:0];
      lb.data = a;
      lb.last = (i == n_pairs - 1);
      ub.data = {{(ACC_WIDTH - OP_WIDTH){b[OP_WIDTH-1]}}, b};
      ub.user = '0;
      ub.user[USER_OP_BIT] = 1'b1;
      // Unaligned case leaves last off the up stream
      ub.last = aligned && (i == n_pairs - 1);
      left_stim.push_back(lb);
      up_stim.push_back(ub);
      if (aligned || i < n_pairs - 1) begin
        exp_right.push_back(lb);
        exp_down.push_back(ub);
      end
      sum = sum + longint'(a) * longint'(b);
    end
    if (aligned) begin
      for (int i = 0; i < n_rslt; i++) begin
        ub.data = rand_bits(ACC_WIDTH);
        ub.user = '0;
        ub.user[USER_RSLT_BIT] = 1'b1;
        ub.last = 1'b1;
        up_stim.push_back(ub);
        exp_down.push_back(ub);
      end
      ub.data = sum[ACC_WIDTH-1:0];
      ub.user = '0;
      ub.user[USER_RSLT_BIT] = 1'b1;
      ub.last = 1'b1;
      exp_down.push_back(ub);
    end else begin
      e = '0;
      e.unaligned = 1'b1;
      exp_err.push_back(e);
    end
  endtask

  task automatic send_left(input left_beat_t beat);
    left_in_valid = 1'b1;
    left_in = beat;
    @(posedge clk);
    while (!left_in_ready) @(posedge clk);
    #1;
    left_in_valid = 1'b0;
  endtask

  task automatic send_up(input up_beat_t beat);
    up_in_valid = 1'b1;
    up_in = beat;
    @(posedge clk);
    while (!up_in_ready) @(posedge clk);
    #1;
    up_in_valid = 1'b0;
  endtask

  task automatic set_ready(input logic right_rdy, input logic down_rdy);
    right_out_ready = right_rdy;
    down_out_ready  = down_rdy;
  endtask

  task automatic drive_left_stream(input int lead);
    if (lead > 0) begin
      repeat (lead) @(posedge clk);
      #1;
    end
    while (left_stim.size() > 0) send_left(left_stim.pop_front());
  endtask

  task automatic drive_up_stream(input int lead);
    if (lead > 0) begin
      repeat (lead) @(posedge clk);
      #1;
    end
    while (up_stim.size() > 0) send_up(up_stim.pop_front());
  endtask

  task automatic run_streams(input int left_lead, input int up_lead);
    fork
      drive_left_stream(left_lead);
      drive_up_stream(up_lead);
    join
  endtask

  // Idle until every expected beat and pulse has shown up
  task automatic wait_drained();
    while (exp_right.size() != 0 || exp_down.size() != 0 || exp_err.size() != 0) begin
      @(posedge clk);
    end
    repeat (8) @(posedge clk);
    #1;
  endtask

  task automatic test_dot_product();
    $display("test: dot product");
    build_product(4, 2, 1'b1);
    run_streams(0, 0);
    wait_drained();
  endtask

  task automatic test_back_to_back();
    $display("test: back-to-back products");
    build_product(4, 2, 1'b1);
    build_product(4, 2, 1'b1);
    run_streams(0, 0);
    wait_drained();
  endtask

  task automatic test_skewed_arrival();
    $display("test: skewed arrival");
    build_product(4, 2, 1'b1);
    run_streams(0, 6);
    wait_drained();
    build_product(4, 2, 1'b1);
    run_streams(6, 0);
    wait_drained();
  endtask

  task automatic test_back_pressure();
    $display("test: back-pressure");
    build_product(4, 2, 1'b1);
    fork
      drive_left_stream(0);
      drive_up_stream(0);
      begin
        while (exp_right.size() != 0 || exp_down.size() != 0) begin
          @(posedge clk);
          #1;
          set_ready(lfsr_bit(), lfsr_bit());
        end
        set_ready(1'b1, 1'b1);
      end
    join
    wait_drained();
  endtask

  task automatic test_unaligned();
    $display("test: unaligned data");
    build_product(4, 0, 1'b0);
    run_streams(0, 0);
    wait_drained();
    build_product(4, 2, 1'b1);
    run_streams(0, 0);
    wait_drained();
  endtask

  task automatic test_bad_user_flag();
    up_beat_t ub;
    lpe_err_t e;
    $display("test: bad user flag");
    ub.data = rand_bits(ACC_WIDTH);
    ub.user = '0;
    ub.user[USER_OP_BIT]   = 1'b1;
    ub.user[USER_RSLT_BIT] = 1'b1;
    ub.last = 1'b0;
    up_stim.push_back(ub);
    e = '0;
    e.user_flag = 1'b1;
    exp_err.push_back(e);
    run_streams(0, 0);
    wait_drained();
    build_product(4, 2, 1'b1);
    run_streams(0, 0);
    wait_drained();
  endtask

  initial begin
    errors = 0;
    checks = 0;
    rst = 1'b1;
    left_in_valid = 1'b0;
    left_in = '0;
    up_in_valid = 1'b0;
    up_in = '0;
    set_ready(1'b1, 1'b1);
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    test_dot_product();
    test_back_to_back();
    test_skewed_arrival();
    test_back_pressure();
    test_unaligned();
    test_bad_user_flag();
    $display("closing: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, beats still outstanding", watchdog_cycles);
    $display("closing: %0d checks, %0d errors", checks, errors);
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* lpe_assertions.sv */
`timescale 1ns/1ps

module lpe_assertions
  import lpe_pkg::*;
(
  input logic       clk,
  input logic       rst,
  input logic       right_out_valid,
  input logic       right_out_ready,
  input left_beat_t right_out,
  input logic       down_out_valid,
  input logic       down_out_ready,
  input up_beat_t   down_out,
  input lpe_err_t   err
);

  // Output beats stay put until taken
  right_hold: assert property (@(posedge clk) disable iff (rst)
    right_out_valid && !right_out_ready |=> right_out_valid && $stable(right_out))
    else $error("right_out beat dropped or changed before transfer");

  down_hold: assert property (@(posedge clk) disable iff (rst)
    down_out_valid && !down_out_ready |=> down_out_valid && $stable(down_out))
    else $error("down_out beat dropped or changed before transfer");

  // One error kind at a time
  err_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(err.unaligned && err.user_flag))
    else $error("both error flags high together");

  err_single: assert property (@(posedge clk) disable iff (rst)
    (err != '0) |=> (err == '0))
    else $error("error flag held longer than one cycle");

endmodule

/* lpe_top.sv */
`timescale 1ns/1ps

module lpe_top
  import lpe_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       left_in_valid,
  output logic       left_in_ready,
  input  left_beat_t left_in,
  input  logic       up_in_valid,
  output logic       up_in_ready,
  input  up_beat_t   up_in,
  output logic       right_out_valid,
  input  logic       right_out_ready,
  output left_beat_t right_out,
  output logic       down_out_valid,
  input  logic       down_out_ready,
  output up_beat_t   down_out,
  output lpe_err_t   err
);

  lpe_ctrl_t            ctrl;
  logic                 left_hold_valid;
  left_beat_t           left_hold;
  logic                 up_hold_valid;
  up_beat_t             up_hold;
  logic                 down_fire;
  logic                 right_fire;
  logic [ACC_WIDTH-1:0] acc;

  lpe_operand_buffer u_buffer (
    .clk             (clk),
    .rst             (rst),
    .left_in_valid   (left_in_valid),
    .left_in_ready   (left_in_ready),
    .left_in         (left_in),
    .up_in_valid     (up_in_valid),
    .up_in_ready     (up_in_ready),
    .up_in           (up_in),
    .ctrl            (ctrl),
    .left_hold_valid (left_hold_valid),
    .left_hold       (left_hold),
    .up_hold_valid   (up_hold_valid),
    .up_hold         (up_hold)
  );

  lpe_control_unit #(
    .pe_position (2)
  ) u_ctrl (
    .clk             (clk),
    .rst             (rst),
    .left_hold_valid (left_hold_valid),
    .left_hold       (left_hold),
    .up_hold_valid   (up_hold_valid),
    .up_hold         (up_hold),
    .down_fire       (down_fire),
    .right_fire      (right_fire),
    .ctrl            (ctrl),
    .err             (err)
  );

  // Operand sits in the low bits of the sign-extended up word
  lpe_mac u_mac (
    .clk          (clk),
    .rst          (rst),
    .a            (left_hold.data),
    .b            (up_hold.data[OP_WIDTH-1:0]),
    .acc_en       (ctrl.forward_u),
    .op_start     (ctrl.op_start),
    .bypass_adder (ctrl.bypass_adder),
    .acc          (acc)
  );

  lpe_output_port u_out (
    .clk             (clk),
    .rst             (rst),
    .ctrl            (ctrl),
    .left_hold       (left_hold),
    .up_hold         (up_hold),
    .acc             (acc),
    .right_out_valid (right_out_valid),
    .right_out_ready (right_out_ready),
    .right_out       (right_out),
    .down_out_valid  (down_out_valid),
    .down_out_ready  (down_out_ready),
    .down_out        (down_out),
    .down_fire       (down_fire),
    .right_fire      (right_fire)
  );

endmodule

/* lpe_output_port.sv */
`timescale 1ns/1ps

module lpe_output_port
  import lpe_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  lpe_ctrl_t            ctrl,
  input  left_beat_t           left_hold,
  input  up_beat_t             up_hold,
  input  logic [ACC_WIDTH-1:0] acc,
  output logic                 right_out_valid,
  input  logic                 right_out_ready,
  output left_beat_t           right_out,
  output logic                 down_out_valid,
  input  logic                 down_out_ready,
  output up_beat_t             down_out,
  output logic                 down_fire,
  output logic                 right_fire
);

  up_beat_t rslt_beat;
  up_beat_t down_next;
  logic     down_load;

  // Own result carries only the result flag and closes the stream
  always_comb begin
    rslt_beat = '0;
    rslt_beat.data = acc;
    rslt_beat.user[USER_RSLT_BIT] = 1'b1;
    rslt_beat.last = 1'b1;
  end

  // Operands and passed results both come straight from the up register
  assign down_next = ctrl.export_rslt ? rslt_beat : up_hold;
  assign down_load = ctrl.forward_u || ctrl.export_rslt;

  assign right_fire = right_out_valid && right_out_ready;
  assign down_fire  = down_out_valid && down_out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      right_out_valid <= 1'b0;
      down_out_valid  <= 1'b0;
    end else begin
      if (ctrl.forward_l) begin
        right_out_valid <= 1'b1;
      end else if (right_fire) begin
        right_out_valid <= 1'b0;
      end
      if (down_load) begin
        down_out_valid <= 1'b1;
      end else if (down_fire) begin
        down_out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.forward_l) begin
      right_out <= left_hold;
    end
    if (down_load) begin
      down_out <= down_next;
    end
  end

endmodule

/* lpe_mac.sv */
`timescale 1ns/1ps

module lpe_mac
  import lpe_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic signed [OP_WIDTH-1:0]  a,
  input  logic signed [OP_WIDTH-1:0]  b,
  input  logic                        acc_en,
  input  logic                        op_start,
  input  logic                        bypass_adder,
  output logic signed [ACC_WIDTH-1:0] acc
);

  logic signed [2*OP_WIDTH-1:0] product;
  logic signed [ACC_WIDTH-1:0]  product_ext;
  logic                         update;

  assign product     = a * b;
  // Sign extension to the accumulator width
  assign product_ext = product;

  assign update = acc_en && !bypass_adder;

  always_ff @(posedge clk) begin
    if (rst) begin
      acc <= '0;
    end else if (update) begin
      if (op_start) begin
        // First pair of a new dot product
        acc <= product_ext;
      end else begin
        acc <= acc + product_ext;
      end
    end
  end

endmodule

/* lpe_control_unit.sv */
`timescale 1ns/1ps

module lpe_control_unit
  import lpe_pkg::*;
#(
  parameter int pe_position = 0
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       left_hold_valid,
  input  left_beat_t left_hold,
  input  logic       up_hold_valid,
  input  up_beat_t   up_hold,
  input  logic       down_fire,
  input  logic       right_fire,
  output lpe_ctrl_t  ctrl,
  output lpe_err_t   err
);

  lpe_state_e state;
  lpe_state_e state_next;

  // Results still expected from elements above
  logic [POS_WIDTH-1:0] pos_cnt;

  logic op_start_q;
  logic rslt_pending;
  logic right_busy;
  logic down_busy;

  logic up_is_op;
  logic up_is_rslt;
  logic up_bad;
  logic up_unflagged;
  logic in_op_state;
  logic unaligned;
  logic err_now;
  logic right_free;
  logic down_free;
  logic pair_go;
  logic pass_rslt;
  logic export_go;
  logic rslt_done;

  // User flag decode
  assign up_is_op     = up_hold_valid && up_hold.user[USER_OP_BIT] &&
                        !up_hold.user[USER_RSLT_BIT];
  assign up_is_rslt   = up_hold_valid && up_hold.user[USER_RSLT_BIT] &&
                        !up_hold.user[USER_OP_BIT];
  assign up_bad       = up_hold_valid && up_hold.user[USER_OP_BIT] &&
                        up_hold.user[USER_RSLT_BIT];
  assign up_unflagged = up_hold_valid && !up_hold.user[USER_OP_BIT] &&
                        !up_hold.user[USER_RSLT_BIT];

  assign in_op_state = (state == STRT) || (state == STRL) ||
                       (state == STRU) || (state == MAC);

  // Both operands present but only one of them closes the product
  assign unaligned = in_op_state && left_hold_valid && up_is_op &&
                     (left_hold.last != up_hold.last);
  assign err_now   = (state != ERR) && (unaligned || up_bad);

  // Output slot is free if empty or draining this cycle
  assign right_free = !right_busy || right_fire;
  assign down_free  = !down_busy || down_fire;

  assign pair_go   = in_op_state && left_hold_valid && up_is_op && !err_now &&
                     right_free && down_free;
  assign pass_rslt = (state != ERR) && up_is_rslt && (pos_cnt != '0) && down_free;
  assign export_go = (state == END) && (pos_cnt == '0) && !rslt_pending &&
                     !err_now && down_free;
  assign rslt_done = (state == END) && rslt_pending && down_fire;

  always_comb begin
    ctrl = '0;
    ctrl.store_l      = (state != ERR);
    ctrl.store_u      = (state != ERR);
    ctrl.forward_l    = pair_go;
    ctrl.forward_u    = pair_go || pass_rslt;
    ctrl.drop_l       = (state == ERR);
    // Words carrying no flag have no meaning in the column
    ctrl.drop_u       = (state == ERR) || up_unflagged;
    ctrl.op_start     = op_start_q;
    ctrl.bypass_adder = !pair_go;
    ctrl.export_rslt  = export_go;
  end

  always_comb begin
    state_next = state;
    case (state)
      STRT, STRL, STRU, MAC: begin
        if (pair_go) begin
          state_next = left_hold.last ? END : MAC;
        end else if (left_hold_valid && !up_is_op) begin
          state_next = STRL;
        end else if (up_is_op && !left_hold_valid) begin
          state_next = STRU;
        end
      end
      END: begin
        // Leave once the own result has gone down
        if (rslt_done) begin
          state_next = STRT;
        end
      end
      ERR: state_next = STRT;
      default: state_next = STRT;
    endcase
    if (err_now) begin
      state_next = ERR;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= STRT;
      pos_cnt      <= POS_WIDTH'(pe_position);
      op_start_q   <= 1'b1;
      rslt_pending <= 1'b0;
      right_busy   <= 1'b0;
      down_busy    <= 1'b0;
      err          <= '0;
    end else begin
      state          <= state_next;
      err.unaligned  <= err_now && unaligned;
      err.user_flag  <= err_now && up_bad;

      // Fresh sum after a flush or an export
      if ((state == ERR) || rslt_done) begin
        op_start_q <= 1'b1;
      end else if (pair_go) begin
        op_start_q <= 1'b0;
      end

      if ((state == ERR) || rslt_done) begin
        pos_cnt <= POS_WIDTH'(pe_position);
      end else if (pass_rslt) begin
        pos_cnt <= pos_cnt - 1'b1;
      end

      if (export_go) begin
        rslt_pending <= 1'b1;
      end else if (rslt_done || (state == ERR)) begin
        rslt_pending <= 1'b0;
      end

      if (ctrl.forward_l) begin
        right_busy <= 1'b1;
      end else if (right_fire) begin
        right_busy <= 1'b0;
      end

      if (ctrl.forward_u || export_go) begin
        down_busy <= 1'b1;
      end else if (down_fire) begin
        down_busy <= 1'b0;
      end
    end
  end

endmodule

/* lpe_operand_buffer.sv */
`timescale 1ns/1ps

module lpe_operand_buffer
  import lpe_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       left_in_valid,
  output logic       left_in_ready,
  input  left_beat_t left_in,
  input  logic       up_in_valid,
  output logic       up_in_ready,
  input  up_beat_t   up_in,
  input  lpe_ctrl_t  ctrl,
  output logic       left_hold_valid,
  output left_beat_t left_hold,
  output logic       up_hold_valid,
  output up_beat_t   up_hold
);

  logic left_consume;
  logic up_consume;
  logic left_take;
  logic up_take;

  // A held beat leaves on forward or drop
  assign left_consume = ctrl.forward_l || ctrl.drop_l;
  assign up_consume   = ctrl.forward_u || ctrl.drop_u;

  // Accept when empty or emptying, and only while store is granted
  assign left_in_ready = ctrl.store_l && (!left_hold_valid || left_consume);
  assign up_in_ready   = ctrl.store_u && (!up_hold_valid || up_consume);

  assign left_take = left_in_valid && left_in_ready;
  assign up_take   = up_in_valid && up_in_ready;

  // Occupancy of the left register
  always_ff @(posedge clk) begin
    if (rst) begin
      left_hold_valid <= 1'b0;
    end else if (left_take) begin
      left_hold_valid <= 1'b1;
    end else if (left_consume) begin
      left_hold_valid <= 1'b0;
    end
  end

  // Occupancy of the up register
  always_ff @(posedge clk) begin
    if (rst) begin
      up_hold_valid <= 1'b0;
    end else if (up_take) begin
      up_hold_valid <= 1'b1;
    end else if (up_consume) begin
      up_hold_valid <= 1'b0;
    end
  end

  // Held beats
  always_ff @(posedge clk) begin
    if (left_take) begin
      left_hold <= left_in;
    end
    if (up_take) begin
      up_hold <= up_in;
    end
  end

endmodule

/* lpe_pkg.sv */
package lpe_pkg;

  // Operand and result widths
  localparam int OP_WIDTH   = 16;
  localparam int ACC_WIDTH  = 40;
  localparam int USER_WIDTH = 8;

  // Flag bits in the up stream user field
  localparam int USER_OP_BIT   = 6;
  localparam int USER_RSLT_BIT = 7;

  // Column geometry
  localparam int PE_NUMBER_J = 4;
  localparam int POS_WIDTH   = $clog2(PE_NUMBER_J);

  // Control unit states
  typedef enum logic [2:0] {
    STRT,
    STRL,
    STRU,
    MAC,
    END,
    ERR
  } lpe_state_e;

  // Beat on the left input and right output
  typedef struct packed {
    logic [OP_WIDTH-1:0] data;
    logic                last;
  } left_beat_t;

  // Beat on the up input and down output with operands sign-extended
  typedef struct packed {
    logic [ACC_WIDTH-1:0]  data;
    logic [USER_WIDTH-1:0] user;
    logic                  last;
  } up_beat_t;

  // Strobes from the control unit to the data path
  typedef struct packed {
    logic store_l;
    logic store_u;
    logic forward_l;
    logic forward_u;
    logic drop_l;
    logic drop_u;
    logic op_start;
    logic bypass_adder;
    logic export_rslt;
  } lpe_ctrl_t;

  // Error flags that each pulse for a single cycle
  typedef struct packed {
    logic unaligned;
    logic user_flag;
  } lpe_err_t;

endpackage
